// ==== src.f ====
logic/ncpu_msr_pkg.sv
logic/cmt_psr.sv
logic/cmt_msr_access.sv
logic/cmt_excp.sv
logic/cmt_msr_top.sv
bench/tb_cmt_msr.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MSR block testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cmt_msr -f src.f

# The simulator exits nonzero on a failure, so the log decides
./obj_dir/Vtb_cmt_msr 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// ==== bench/tb_cmt_msr.sv ====
// Testbench for the commit stage MSR block
// Drives MSR accesses, exceptions and erets, and compares read data
// and redirects with a shadow register model every cycle
`timescale 1ns/100ps

module tb_cmt_msr
   import ncpu_msr_pkg::*;
();

   localparam int       DW          = 64;
   localparam bit [7:0] VER         = 8'h21;
   localparam bit [9:0] REV         = 10'h155;
   localparam bit [7:0] FEAT        = 8'ha5;
   localparam int       RAND_CYCLES = 300;
   localparam int       WAIT_MAX    = 16;

   // PSR word keeps bits 9:4 and reads zero elsewhere
   localparam logic [DW-1:0] PSR_MASK  = 64'h0000_0000_0000_03f0;
   localparam logic [DW-1:0] RM_MASK   = 64'd1 << PSR_RM_BIT;
   localparam logic [DW-1:0] CLR_MASK  = (64'd1 << PSR_IRE_BIT) | (64'd1 << PSR_IMME_BIT) |
                                         (64'd1 << PSR_DMME_BIT);
   localparam logic [DW-1:0] MODE_MASK = RM_MASK | CLR_MASK;
   localparam logic [DW-1:0] VECT_MASK = ~((64'd1 << EXCP_VECT_W) - 64'd1);
   localparam logic [DW-1:0] CPUID_EXP = {38'd0, FEAT, REV, VER};

   logic                    clk;
   logic                    rst;
   logic                    msr_we;
   logic [MSR_ADDR_W-1:0]   msr_addr;
   logic [DW-1:0]           msr_wdat;
   logic [DW-1:0]           msr_rdat;
   logic                    excp_valid;
   logic [EXCP_CAUSE_W-1:0] excp_cause;
   logic [DW-1:0]           excp_pc;
   logic [DW-1:0]           excp_lsa;
   logic                    eret;
   logic                    redirect_valid;
   logic [DW-1:0]           redirect_pc;

   // Shadow state and its value after this cycle's events
   logic [DW-1:0] m_psr, m_epsr, m_epc, m_elsa, m_evect;
   logic [DW-1:0] n_psr, n_epsr, n_epc, n_elsa, n_evect;
   logic [DW-1:0] m_sr [NCPU_SR_NUM];
   logic [DW-1:0] n_sr [NCPU_SR_NUM];
   logic [DW-1:0] exp_rdat;
   logic [DW:0]   exp_redir;
   string         test_name;
   integer        seed;

   cmt_msr_top #(
      .CONFIG_DW(DW), .CPUID_VER(VER), .CPUID_REV(REV), .CPUID_FEAT(FEAT)
   ) i_cmt_msr_top (
      .clk, .rst, .msr_we, .msr_addr, .msr_wdat, .msr_rdat,
      .excp_valid, .excp_cause, .excp_pc, .excp_lsa, .eret,
      .redirect_valid, .redirect_pc
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Address 7 is a hole in the map
   function automatic logic [MSR_ADDR_W-1:0] valid_addr(input int idx);
      return (idx < 7) ? 4'(idx) : 4'(idx + 1);
   endfunction

   function automatic void reset_model();
      m_psr   = RM_MASK;
      m_epsr  = '0;
      m_epc   = '0;
      m_elsa  = '0;
      m_evect = '0;
      for (int i = 0; i < NCPU_SR_NUM; i++)
         m_sr[i] = '0;
   endfunction

   // Next state from the current inputs is also the bypassed view
   function automatic void compute_next();
      logic [DW-1:0] pre;
      pre     = m_psr;
      n_epsr  = m_epsr;
      n_epc   = m_epc;
      n_elsa  = m_elsa;
      n_evect = m_evect;
      n_sr    = m_sr;
      if (msr_we)
      begin
         case (msr_addr)
            MSR_PSR:   pre = msr_wdat & PSR_MASK;
            MSR_EPSR:  n_epsr = msr_wdat & PSR_MASK;
            MSR_EPC:   n_epc = msr_wdat;
            MSR_ELSA:  n_elsa = msr_wdat;
            MSR_EVECT: n_evect = msr_wdat & VECT_MASK;
            MSR_SR0:   n_sr[0] = msr_wdat;
            MSR_SR1:   n_sr[1] = msr_wdat;
            MSR_SR2:   n_sr[2] = msr_wdat;
            MSR_SR3:   n_sr[3] = msr_wdat;
            default:   ;
         endcase
      end
      if (excp_valid)
      begin
         n_epsr = pre;
         n_psr  = (pre | RM_MASK) & ~CLR_MASK;
         n_epc  = excp_pc;
         if (excp_cause == EXCP_ALIGN)
            n_elsa = excp_lsa;
      end
      else if (eret)
         n_psr = (pre & ~MODE_MASK) | (m_epsr & MODE_MASK);
      else
         n_psr = pre;
   endfunction

   function automatic void commit_model();
      m_psr   = n_psr;
      m_epsr  = n_epsr;
      m_epc   = n_epc;
      m_elsa  = n_elsa;
      m_evect = n_evect;
      m_sr    = n_sr;
   endfunction

   function automatic logic [DW-1:0] ref_rdat(input logic [MSR_ADDR_W-1:0] addr);
      case (addr)
         MSR_PSR:   return n_psr;
         MSR_CPUID: return CPUID_EXP;
         MSR_EPSR:  return n_epsr;
         MSR_EPC:   return n_epc;
         MSR_ELSA:  return n_elsa;
         MSR_EVECT: return n_evect;
         MSR_SR0:   return n_sr[0];
         MSR_SR1:   return n_sr[1];
         MSR_SR2:   return n_sr[2];
         MSR_SR3:   return n_sr[3];
         default:   return '0;
      endcase
   endfunction

   // Valid flag on top of the target
   function automatic logic [DW:0] ref_redirect();
      logic [DW-1:0] off;
      off = 64'(excp_cause) << 8;
      if (excp_valid)
         return {1'b1, n_evect | off};
      else if (eret)
         return {1'b1, n_epc};
      else
         return {1'b0, 64'd0};
   endfunction

   task automatic report_fail(input string what, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
      $display("FAILED %s: expected %h, actual %h", what, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at first mismatch");
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: no %s within %0d cycles", what, WAIT_MAX);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped on timeout");
   endtask

   always @(negedge clk)
   begin
      if (rst)
         reset_model();
      else
      begin
         compute_next();
         exp_rdat  = ref_rdat(msr_addr);
         exp_redir = ref_redirect();
         assert (msr_rdat === exp_rdat)
            else report_fail({test_name, " msr_rdat"}, exp_rdat, msr_rdat);
         assert (redirect_valid === exp_redir[DW])
            else report_fail({test_name, " redirect_valid"}, 64'(exp_redir[DW]),
                             64'(redirect_valid));
         if (exp_redir[DW])
            assert (redirect_pc === exp_redir[DW-1:0])
               else report_fail({test_name, " redirect_pc"}, exp_redir[DW-1:0], redirect_pc);
         commit_model();
      end
   end

   task automatic drive(input string name, input logic we, input logic [3:0] addr,
                        input logic [DW-1:0] wdat, input logic ev, input logic [3:0] cause,
                        input logic [DW-1:0] pc, input logic [DW-1:0] lsa, input logic er);
      @(posedge clk);
      test_name  <= name;
      msr_we     <= we;
      msr_addr   <= addr;
      msr_wdat   <= wdat;
      excp_valid <= ev;
      excp_cause <= cause;
      excp_pc    <= pc;
      excp_lsa   <= lsa;
      eret       <= er;
   endtask

   task automatic write_msr(input string name, input logic [3:0] addr, input logic [DW-1:0] wdat);
      drive(name, 1'b1, addr, wdat, 1'b0, 4'h0, 64'h0, 64'h0, 1'b0);
   endtask

   task automatic read_msr(input string name, input logic [3:0] addr);
      drive(name, 1'b0, addr, 64'h0, 1'b0, 4'h0, 64'h0, 64'h0, 1'b0);
   endtask

   task automatic expect_rdat(input string name, input logic [DW-1:0] exp);
      @(negedge clk);
      assert (msr_rdat === exp)
         else report_fail({name, " msr_rdat"}, exp, msr_rdat);
   endtask

   task automatic expect_redirect(input string name, input logic [DW-1:0] exp);
      int n;
      n = 0;
      @(negedge clk);
      while (redirect_valid !== 1'b1 && n < WAIT_MAX)
      begin
         @(negedge clk);
         n++;
      end
      if (redirect_valid !== 1'b1)
         report_timeout({name, " redirect"});
      assert (redirect_pc === exp)
         else report_fail({name, " redirect_pc"}, exp, redirect_pc);
   endtask

   initial
   begin
      logic [31:0]           r;
      logic [DW-1:0]         d;
      logic [MSR_ADDR_W-1:0] a;
      logic                  w;
      logic                  ev;
      logic                  er;
      seed       = 32'hbf1e;
      test_name  = "reset";
      rst        = 1'b1;
      msr_we     = 1'b0;
      msr_addr   = '0;
      msr_wdat   = '0;
      excp_valid = 1'b0;
      excp_cause = '0;
      excp_pc    = '0;
      excp_lsa   = '0;
      eret       = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // Reset values
      read_msr("reset_psr", MSR_PSR);
      expect_rdat("reset_psr", 64'h10);
      read_msr("reset_cpuid", MSR_CPUID);
      expect_rdat("reset_cpuid", 64'h0000_0000_0295_5521);
      for (int i = 0; i < 11; i++)
         read_msr("reset_all", valid_addr(i));

      // Write and read back through the bypass
      for (int i = 0; i < 11; i++)
         write_msr("write_all", valid_addr(i), {$random(seed), $random(seed)});
      write_msr("write_sr1", MSR_SR1, 64'hdead_beef_0123_4567);
      expect_rdat("write_sr1", 64'hdead_beef_0123_4567);
      read_msr("read_sr1", MSR_SR1);
      expect_rdat("read_sr1", 64'hdead_beef_0123_4567);
      write_msr("write_evect", MSR_EVECT, 64'h8000_0000_1234_5fff);
      expect_rdat("write_evect", 64'h8000_0000_1234_5000);
      write_msr("write_psr", MSR_PSR, 64'hffff);
      expect_rdat("write_psr", 64'h3f0);
      write_msr("write_cpuid", MSR_CPUID, '1);
      expect_rdat("write_cpuid", 64'h0000_0000_0295_5521);
      write_msr("write_coreid", MSR_COREID, '1);
      expect_rdat("write_coreid", 64'h0);

      // Exception with a PSR write in the same cycle
      drive("excp_align", 1'b1, MSR_PSR, 64'h3e0, 1'b1, EXCP_ALIGN,
            64'h1000_0040, 64'h2000_0003, 1'b0);
      expect_redirect("excp_align", 64'h8000_0000_1234_5200);
      read_msr("excp_epsr", MSR_EPSR);
      expect_rdat("excp_epsr", 64'h3e0);
      read_msr("excp_psr", MSR_PSR);
      expect_rdat("excp_psr", 64'h310);
      read_msr("excp_epc", MSR_EPC);
      expect_rdat("excp_epc", 64'h1000_0040);
      drive("excp_syscall", 1'b0, MSR_ELSA, 64'h0, 1'b1, EXCP_SYSCALL,
            64'h1000_0080, 64'h5555, 1'b0);
      expect_redirect("excp_syscall", 64'h8000_0000_1234_5000);
      read_msr("excp_elsa", MSR_ELSA);
      expect_rdat("excp_elsa", 64'h2000_0003);

      // Return from exception, then exception and eret together
      write_msr("eret_setup", MSR_EPSR, 64'h0e0);
      write_msr("eret_setup", MSR_PSR, 64'h200);
      drive("eret", 1'b0, MSR_PSR, 64'h0, 1'b0, 4'h0, 64'h0, 64'h0, 1'b1);
      expect_redirect("eret", 64'h1000_0080);
      read_msr("eret_psr", MSR_PSR);
      expect_rdat("eret_psr", 64'h2e0);
      drive("excp_eret", 1'b0, MSR_EPC, 64'h0, 1'b1, EXCP_IRQ, 64'h1000_00c0, 64'h0, 1'b1);
      expect_redirect("excp_eret", 64'h8000_0000_1234_5300);
      read_msr("excp_eret_psr", MSR_PSR);
      expect_rdat("excp_eret_psr", 64'h210);

      // Random mix
      for (int i = 0; i < RAND_CYCLES; i++)
      begin
         r  = $random(seed);
         d  = {$random(seed), $random(seed)};
         a  = valid_addr(int'(r[23:16]) % 11);
         w  = r[0];
         ev = (r[10:8] == 3'd0);
         er = (r[13:11] == 3'd0);
         drive("random", w, a, d, ev, {2'b00, r[15:14]}, {r, d[31:0]}, ~d, er);
      end
      read_msr("idle", MSR_PSR);
      @(negedge clk);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== logic/cmt_msr_top.sv ====
// MSR block of the commit stage
// Connects the access decoder, exception sequencer and the
// register file
`timescale 1ns/100ps

module cmt_msr_top
   import ncpu_msr_pkg::*;
#(
   parameter int       CONFIG_DW  = 64,
   parameter bit [7:0] CPUID_VER  = 8'd1,
   parameter bit [9:0] CPUID_REV  = 10'd0,
   parameter bit [7:0] CPUID_FEAT = 8'h0f
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    msr_we,
   input  logic [MSR_ADDR_W-1:0]   msr_addr,
   input  logic [CONFIG_DW-1:0]    msr_wdat,
   output logic [CONFIG_DW-1:0]    msr_rdat,
   input  logic                    excp_valid,
   input  logic [EXCP_CAUSE_W-1:0] excp_cause,
   input  logic [CONFIG_DW-1:0]    excp_pc,
   input  logic [CONFIG_DW-1:0]    excp_lsa,
   input  logic                    eret,
   output logic                    redirect_valid,
   output logic [CONFIG_DW-1:0]    redirect_pc
);

   logic psr_rm_we, psr_rm_nxt, psr_ire_we, psr_ire_nxt;
   logic psr_imme_we, psr_imme_nxt, psr_dmme_we, psr_dmme_nxt;
   logic psr_ice_we, psr_ice_nxt, psr_dce_we, psr_dce_nxt;
   logic                             epsr_we;
   logic [NCPU_PSR_DW-1:0]           epsr_nxt;
   logic                             epc_we;
   logic [CONFIG_DW-1:0]             epc_nxt;
   logic                             elsa_we;
   logic [CONFIG_DW-1:0]             elsa_nxt;
   logic                             evect_we;
   logic [CONFIG_DW-1:EXCP_VECT_W]   evect_nxt;
   logic [NCPU_SR_NUM-1:0]           sr_we;
   logic [CONFIG_DW-1:0]             sr_nxt;
   logic                             psr_save;
   logic                             psr_restore;
   logic                             epc_cap;
   logic [CONFIG_DW-1:0]             excp_epc;
   logic                             elsa_cap;
   logic [CONFIG_DW-1:0]             excp_elsa;
   logic [NCPU_PSR_DW-1:0]           psr;
   logic [NCPU_PSR_DW-1:0]           epsr;
   logic [CONFIG_DW-1:0]             epc;
   logic [CONFIG_DW-1:0]             elsa;
   logic [CONFIG_DW-1:EXCP_VECT_W]   evect;
   logic [CONFIG_DW*NCPU_SR_NUM-1:0] sr;

   cmt_msr_access #(
      .CONFIG_DW(CONFIG_DW), .CPUID_VER(CPUID_VER),
      .CPUID_REV(CPUID_REV), .CPUID_FEAT(CPUID_FEAT)
   ) u_msr_access (
      .msr_we, .msr_addr, .msr_wdat, .msr_rdat,
      .psr_rm_we, .psr_rm_nxt, .psr_ire_we, .psr_ire_nxt,
      .psr_imme_we, .psr_imme_nxt, .psr_dmme_we, .psr_dmme_nxt,
      .psr_ice_we, .psr_ice_nxt, .psr_dce_we, .psr_dce_nxt,
      .epsr_we, .epsr_nxt, .epc_we, .epc_nxt, .elsa_we, .elsa_nxt,
      .evect_we, .evect_nxt, .sr_we, .sr_nxt,
      .psr, .epsr, .epc, .elsa, .evect, .sr
   );

   cmt_excp #(
      .CONFIG_DW(CONFIG_DW)
   ) u_excp (
      .excp_valid, .excp_cause, .excp_pc, .excp_lsa, .eret,
      .evect, .epc,
      .psr_save, .psr_restore, .epc_cap, .excp_epc, .elsa_cap, .excp_elsa,
      .redirect_valid, .redirect_pc
   );

   cmt_psr #(
      .CONFIG_DW(CONFIG_DW)
   ) u_psr (
      .clk, .rst, .psr_save, .psr_restore,
      .psr_rm_we, .psr_rm_nxt, .psr_ire_we, .psr_ire_nxt,
      .psr_imme_we, .psr_imme_nxt, .psr_dmme_we, .psr_dmme_nxt,
      .psr_ice_we, .psr_ice_nxt, .psr_dce_we, .psr_dce_nxt,
      .epsr_we, .epsr_nxt, .epc_we, .epc_nxt, .elsa_we, .elsa_nxt,
      .epc_cap, .excp_epc, .elsa_cap, .excp_elsa,
      .evect_we, .evect_nxt, .sr_we, .sr_nxt,
      .psr, .epsr, .epc, .elsa, .evect, .sr
   );

endmodule

// ==== logic/cmt_excp.sv ====
// Exception sequencer
// Turns exception and eret events into PSR save/restore,
// EPC/ELSA capture and a same-cycle redirect target
`timescale 1ns/100ps

module cmt_excp
   import ncpu_msr_pkg::*;
#(
   parameter int CONFIG_DW = 64
)
(
   input  logic                           excp_valid,
   input  logic [EXCP_CAUSE_W-1:0]        excp_cause,
   input  logic [CONFIG_DW-1:0]           excp_pc,
   input  logic [CONFIG_DW-1:0]           excp_lsa,
   input  logic                           eret,
   input  logic [CONFIG_DW-1:EXCP_VECT_W] evect,
   input  logic [CONFIG_DW-1:0]           epc,
   output logic                           psr_save,
   output logic                           psr_restore,
   output logic                           epc_cap,
   output logic [CONFIG_DW-1:0]           excp_epc,
   output logic                           elsa_cap,
   output logic [CONFIG_DW-1:0]           excp_elsa,
   output logic                           redirect_valid,
   output logic [CONFIG_DW-1:0]           redirect_pc
);

   excp_cause_e            cause;
   logic                   do_eret;
   logic [EXCP_VECT_W-1:0] vect_off;

   assign cause = excp_cause_e'(excp_cause);

   // Exception masks a coincident eret
   assign do_eret = eret & ~excp_valid;

   assign psr_save    = excp_valid;
   assign psr_restore = do_eret;
   assign epc_cap     = excp_valid;
   assign excp_epc    = excp_pc;

   // Only misaligned accesses record the faulting address
   assign elsa_cap  = excp_valid & (cause == EXCP_ALIGN);
   assign excp_elsa = excp_lsa;

   // Cause selects a 256-byte slot in the vector page
   assign vect_off = {cause, 8'h00};

   assign redirect_valid = excp_valid | do_eret;
   assign redirect_pc    = excp_valid ? {evect, vect_off} : epc;

endmodule

// ==== logic/cmt_msr_access.sv ====
// MSR access decoder
// Turns a move-to-MSR write into per-register strobes and
// returns read data for a move-from-MSR by address
`timescale 1ns/100ps

module cmt_msr_access
   import ncpu_msr_pkg::*;
#(
   parameter int       CONFIG_DW  = 64,
   parameter bit [7:0] CPUID_VER  = 8'd1,
   parameter bit [9:0] CPUID_REV  = 10'd0,
   parameter bit [7:0] CPUID_FEAT = 8'h00
)
(
   input  logic                             msr_we,
   input  logic [MSR_ADDR_W-1:0]            msr_addr,
   input  logic [CONFIG_DW-1:0]             msr_wdat,
   output logic [CONFIG_DW-1:0]             msr_rdat,
   output logic                             psr_rm_we,
   output logic                             psr_rm_nxt,
   output logic                             psr_ire_we,
   output logic                             psr_ire_nxt,
   output logic                             psr_imme_we,
   output logic                             psr_imme_nxt,
   output logic                             psr_dmme_we,
   output logic                             psr_dmme_nxt,
   output logic                             psr_ice_we,
   output logic                             psr_ice_nxt,
   output logic                             psr_dce_we,
   output logic                             psr_dce_nxt,
   output logic                             epsr_we,
   output logic [NCPU_PSR_DW-1:0]           epsr_nxt,
   output logic                             epc_we,
   output logic [CONFIG_DW-1:0]             epc_nxt,
   output logic                             elsa_we,
   output logic [CONFIG_DW-1:0]             elsa_nxt,
   output logic                             evect_we,
   output logic [CONFIG_DW-1:EXCP_VECT_W]   evect_nxt,
   output logic [NCPU_SR_NUM-1:0]           sr_we,
   output logic [CONFIG_DW-1:0]             sr_nxt,
   input  logic [NCPU_PSR_DW-1:0]           psr,
   input  logic [NCPU_PSR_DW-1:0]           epsr,
   input  logic [CONFIG_DW-1:0]             epc,
   input  logic [CONFIG_DW-1:0]             elsa,
   input  logic [CONFIG_DW-1:EXCP_VECT_W]   evect,
   input  logic [CONFIG_DW*NCPU_SR_NUM-1:0] sr
);

   msr_addr_e            addr;
   logic                 psr_we;
   logic [CONFIG_DW-1:0] cpuid;

   assign addr = msr_addr_e'(msr_addr);

   // Version, revision, then feature bits
   assign cpuid = {{(CONFIG_DW-26){1'b0}}, CPUID_FEAT, CPUID_REV, CPUID_VER};

   // One strobe per write, CPUID and COREID fall through
   always_comb
   begin
      psr_we   = 1'b0;
      epsr_we  = 1'b0;
      epc_we   = 1'b0;
      elsa_we  = 1'b0;
      evect_we = 1'b0;
      sr_we    = '0;
      if (msr_we)
      begin
         case (addr)
            MSR_PSR:   psr_we = 1'b1;
            MSR_EPSR:  epsr_we = 1'b1;
            MSR_EPC:   epc_we = 1'b1;
            MSR_ELSA:  elsa_we = 1'b1;
            MSR_EVECT: evect_we = 1'b1;
            MSR_SR0:   sr_we[0] = 1'b1;
            MSR_SR1:   sr_we[1] = 1'b1;
            MSR_SR2:   sr_we[2] = 1'b1;
            MSR_SR3:   sr_we[3] = 1'b1;
            default:   ;
         endcase
      end
   end

   // A PSR write loads every bit at once
   assign psr_rm_we    = psr_we;
   assign psr_ire_we   = psr_we;
   assign psr_imme_we  = psr_we;
   assign psr_dmme_we  = psr_we;
   assign psr_ice_we   = psr_we;
   assign psr_dce_we   = psr_we;
   assign psr_rm_nxt   = msr_wdat[PSR_RM_BIT];
   assign psr_ire_nxt  = msr_wdat[PSR_IRE_BIT];
   assign psr_imme_nxt = msr_wdat[PSR_IMME_BIT];
   assign psr_dmme_nxt = msr_wdat[PSR_DMME_BIT];
   assign psr_ice_nxt  = msr_wdat[PSR_ICE_BIT];
   assign psr_dce_nxt  = msr_wdat[PSR_DCE_BIT];

   // Low EPSR bits stay zero
   assign epsr_nxt  = {msr_wdat[NCPU_PSR_DW-1:4], 4'b0000};
   assign epc_nxt   = msr_wdat;
   assign elsa_nxt  = msr_wdat;
   assign evect_nxt = msr_wdat[CONFIG_DW-1:EXCP_VECT_W];
   assign sr_nxt    = msr_wdat;

   always_comb
   begin
      msr_rdat = '0;
      case (addr)
         MSR_PSR:   msr_rdat = CONFIG_DW'(psr);
         MSR_CPUID: msr_rdat = cpuid;
         MSR_EPSR:  msr_rdat = CONFIG_DW'(epsr);
         MSR_EPC:   msr_rdat = epc;
         MSR_ELSA:  msr_rdat = elsa;
         MSR_EVECT: msr_rdat = {evect, {EXCP_VECT_W{1'b0}}};
         MSR_SR0:   msr_rdat = sr[0*CONFIG_DW +: CONFIG_DW];
         MSR_SR1:   msr_rdat = sr[1*CONFIG_DW +: CONFIG_DW];
         MSR_SR2:   msr_rdat = sr[2*CONFIG_DW +: CONFIG_DW];
         MSR_SR3:   msr_rdat = sr[3*CONFIG_DW +: CONFIG_DW];
         default:   msr_rdat = '0;
      endcase
   end

endmodule

// ==== logic/cmt_psr.sv ====
// MSR register file
// Holds PSR, EPSR, EPC, ELSA, EVECT and the scratch registers,
// merges exception save/restore with software writes and bypasses
// every write to the outputs in the same cycle
`timescale 1ns/100ps

module cmt_psr
   import ncpu_msr_pkg::*;
#(
   parameter int CONFIG_DW = 64
)
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             psr_save,
   input  logic                             psr_restore,
   input  logic                             psr_rm_we,
   input  logic                             psr_rm_nxt,
   input  logic                             psr_ire_we,
   input  logic                             psr_ire_nxt,
   input  logic                             psr_imme_we,
   input  logic                             psr_imme_nxt,
   input  logic                             psr_dmme_we,
   input  logic                             psr_dmme_nxt,
   input  logic                             psr_ice_we,
   input  logic                             psr_ice_nxt,
   input  logic                             psr_dce_we,
   input  logic                             psr_dce_nxt,
   input  logic                             epsr_we,
   input  logic [NCPU_PSR_DW-1:0]           epsr_nxt,
   input  logic                             epc_we,
   input  logic [CONFIG_DW-1:0]             epc_nxt,
   input  logic                             elsa_we,
   input  logic [CONFIG_DW-1:0]             elsa_nxt,
   input  logic                             epc_cap,
   input  logic [CONFIG_DW-1:0]             excp_epc,
   input  logic                             elsa_cap,
   input  logic [CONFIG_DW-1:0]             excp_elsa,
   input  logic                             evect_we,
   input  logic [CONFIG_DW-1:EXCP_VECT_W]   evect_nxt,
   input  logic [NCPU_SR_NUM-1:0]           sr_we,
   input  logic [CONFIG_DW-1:0]             sr_nxt,
   output logic [NCPU_PSR_DW-1:0]           psr,
   output logic [NCPU_PSR_DW-1:0]           epsr,
   output logic [CONFIG_DW-1:0]             epc,
   output logic [CONFIG_DW-1:0]             elsa,
   output logic [CONFIG_DW-1:EXCP_VECT_W]   evect,
   output logic [CONFIG_DW*NCPU_SR_NUM-1:0] sr
);

   logic rm_q, ire_q, imme_q, dmme_q, ice_q, dce_q;
   logic rm_we_r, ire_we_r, imme_we_r, dmme_we_r;
   logic rm_nxt_r, ire_nxt_r, imme_nxt_r, dmme_nxt_r;
   logic rm_ld, ire_ld, imme_ld, dmme_ld;
   logic rm_d, ire_d, imme_d, dmme_d;
   logic [NCPU_PSR_DW-1:0]           psr_nold;
   logic [NCPU_PSR_DW-1:0]           epsr_q;
   logic                             epsr_ld;
   logic [NCPU_PSR_DW-1:0]           epsr_d;
   logic                             epc_ld;
   logic [CONFIG_DW-1:0]             epc_d;
   logic [CONFIG_DW-1:0]             epc_q;
   logic                             elsa_ld;
   logic [CONFIG_DW-1:0]             elsa_d;
   logic [CONFIG_DW-1:0]             elsa_q;
   logic [CONFIG_DW-1:EXCP_VECT_W]   evect_q;
   logic [CONFIG_DW*NCPU_SR_NUM-1:0] sr_q;

   // Restore takes the mode bits from the registered EPSR
   assign rm_we_r    = psr_rm_we | psr_restore;
   assign ire_we_r   = psr_ire_we | psr_restore;
   assign imme_we_r  = psr_imme_we | psr_restore;
   assign dmme_we_r  = psr_dmme_we | psr_restore;
   assign rm_nxt_r   = psr_restore ? epsr_q[PSR_RM_BIT] : psr_rm_nxt;
   assign ire_nxt_r  = psr_restore ? epsr_q[PSR_IRE_BIT] : psr_ire_nxt;
   assign imme_nxt_r = psr_restore ? epsr_q[PSR_IMME_BIT] : psr_imme_nxt;
   assign dmme_nxt_r = psr_restore ? epsr_q[PSR_DMME_BIT] : psr_dmme_nxt;

   // Save forces kernel mode, masks interrupts and MMUs
   assign rm_ld   = rm_we_r | psr_save;
   assign ire_ld  = ire_we_r | psr_save;
   assign imme_ld = imme_we_r | psr_save;
   assign dmme_ld = dmme_we_r | psr_save;
   assign rm_d    = rm_nxt_r | psr_save;
   assign ire_d   = ire_nxt_r & ~psr_save;
   assign imme_d  = imme_nxt_r & ~psr_save;
   assign dmme_d  = dmme_nxt_r & ~psr_save;

   // Save beats a software EPSR write
   assign epsr_ld = epsr_we | psr_save;
   assign epsr_d  = psr_save ? psr_nold : epsr_nxt;

   // Hardware capture beats software writes
   assign epc_ld  = epc_we | epc_cap;
   assign epc_d   = epc_cap ? excp_epc : epc_nxt;
   assign elsa_ld = elsa_we | elsa_cap;
   assign elsa_d  = elsa_cap ? excp_elsa : elsa_nxt;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rm_q    <= 1'b1;
         ire_q   <= 1'b0;
         imme_q  <= 1'b0;
         dmme_q  <= 1'b0;
         ice_q   <= 1'b0;
         dce_q   <= 1'b0;
         epsr_q  <= '0;
         epc_q   <= '0;
         elsa_q  <= '0;
         evect_q <= '0;
      end
      else
      begin
         if (rm_ld) rm_q <= rm_d;
         if (ire_ld) ire_q <= ire_d;
         if (imme_ld) imme_q <= imme_d;
         if (dmme_ld) dmme_q <= dmme_d;
         if (psr_ice_we) ice_q <= psr_ice_nxt;
         if (psr_dce_we) dce_q <= psr_dce_nxt;
         if (epsr_ld) epsr_q <= epsr_d;
         if (epc_ld) epc_q <= epc_d;
         if (elsa_ld) elsa_q <= elsa_d;
         if (evect_we) evect_q <= evect_nxt;
      end
   end

   // Scratch registers share one data bus
   for (genvar i = 0; i < NCPU_SR_NUM; i++)
   begin : gen_sr
      always_ff @(posedge clk)
      begin
         if (rst)
            sr_q[i*CONFIG_DW +: CONFIG_DW] <= '0;
         else if (sr_we[i])
            sr_q[i*CONFIG_DW +: CONFIG_DW] <= sr_nxt;
      end

      assign sr[i*CONFIG_DW +: CONFIG_DW] = sr_we[i] ? sr_nxt : sr_q[i*CONFIG_DW +: CONFIG_DW];
   end

   // Bypassed PSR and the view without save applied
   always_comb
   begin
      psr = '0;
      psr[PSR_RM_BIT]   = rm_ld ? rm_d : rm_q;
      psr[PSR_IRE_BIT]  = ire_ld ? ire_d : ire_q;
      psr[PSR_IMME_BIT] = imme_ld ? imme_d : imme_q;
      psr[PSR_DMME_BIT] = dmme_ld ? dmme_d : dmme_q;
      psr[PSR_ICE_BIT]  = psr_ice_we ? psr_ice_nxt : ice_q;
      psr[PSR_DCE_BIT]  = psr_dce_we ? psr_dce_nxt : dce_q;
      psr_nold = psr;
      psr_nold[PSR_RM_BIT]   = rm_we_r ? rm_nxt_r : rm_q;
      psr_nold[PSR_IRE_BIT]  = ire_we_r ? ire_nxt_r : ire_q;
      psr_nold[PSR_IMME_BIT] = imme_we_r ? imme_nxt_r : imme_q;
      psr_nold[PSR_DMME_BIT] = dmme_we_r ? dmme_nxt_r : dmme_q;
   end

   assign epsr  = epsr_ld ? epsr_d : epsr_q;
   assign epc   = epc_ld ? epc_d : epc_q;
   assign elsa  = elsa_ld ? elsa_d : elsa_q;
   assign evect = evect_we ? evect_nxt : evect_q;

endmodule

// ==== logic/ncpu_msr_pkg.sv ====
// Machine state register definitions
// Widths, PSR bit layout, MSR address map and exception causes
// shared by the commit stage MSR block
package ncpu_msr_pkg;

   // PSR and EPSR width, bits 3:0 read as zero
   localparam int NCPU_PSR_DW = 10;

   // PSR bit positions
   localparam int PSR_RM_BIT   = 4;
   localparam int PSR_IRE_BIT  = 5;
   localparam int PSR_IMME_BIT = 6;
   localparam int PSR_DMME_BIT = 7;
   localparam int PSR_ICE_BIT  = 8;
   localparam int PSR_DCE_BIT  = 9;

   // Scratch register count
   localparam int NCPU_SR_NUM = 4;

   // Low vector bits not held in EVECT
   localparam int EXCP_VECT_W = 12;

   localparam int MSR_ADDR_W = 4;
   localparam int EXCP_CAUSE_W = 4;

   typedef enum logic [MSR_ADDR_W-1:0] {
      MSR_PSR    = 4'h0,
      MSR_CPUID  = 4'h1,
      MSR_EPSR   = 4'h2,
      MSR_EPC    = 4'h3,
      MSR_ELSA   = 4'h4,
      MSR_COREID = 4'h5,
      MSR_EVECT  = 4'h6,
      MSR_SR0    = 4'h8,
      MSR_SR1    = 4'h9,
      MSR_SR2    = 4'ha,
      MSR_SR3    = 4'hb
   } msr_addr_e;

   // Offset in the vector page is cause * 256
   typedef enum logic [EXCP_CAUSE_W-1:0] {
      EXCP_SYSCALL = 4'h0,
      EXCP_ILLEGAL = 4'h1,
      EXCP_ALIGN   = 4'h2,
      EXCP_IRQ     = 4'h3
   } excp_cause_e;

endpackage
